// File: hw/tof_params.svh
`ifndef TOF_PARAMS_SVH
`define TOF_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

`define TOF_ADDR_W      16      // Sensor register address
`define TOF_DATA_W      8

////////////////////////////////////////////////////////////
// Result frame layout
////////////////////////////////////////////////////////////

// Header bytes 0 to 27, distances 28 to 155, footer up to 179
`define TOF_FRAME_BYTES 180
`define TOF_DIST_FIRST  28
`define TOF_ZONES       64      // 8x8 zones, two bytes each

// Boot segments plus start-ranging segment
`define TOF_SCRIPT_LEN  70

`endif

// File: hw/tof_bus_pkg.sv
`include "tof_params.svh"

package tof_bus_pkg;

    typedef logic [`TOF_ADDR_W-1:0] reg_addr_t;
    typedef logic [`TOF_DATA_W-1:0] bus_byte_t;

    // One register access of a script, 26 bits
    typedef struct packed {
        reg_addr_t addr;
        bus_byte_t value;
        logic      rd;      // Read access, value unused
        logic      last;    // Last entry of its segment
    } script_entry_t;

    typedef logic [$clog2(`TOF_SCRIPT_LEN)-1:0] script_idx_t;

    ////////////////////////////////////////////////////////////
    // Ranging results
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(`TOF_ZONES)-1:0] zone_t;
    typedef logic [2*`TOF_DATA_W-1:0]      distance_t;    // mm

endpackage

// File: hw/tof_cmd_pkg.sv
package tof_cmd_pkg;

    // Host command codes
    typedef enum logic [3:0] {
        SW_REBOOT1       = 4'd1,
        SW_REBOOT2       = 4'd2,
        SW_REBOOT3       = 4'd3,
        DOWNLOAD_DATA    = 4'd4,    // Read frame now
        RESET_MCU        = 4'd6,
        START_RANGING    = 4'd13,
        DATA_ACQUISITION = 4'd14    // Wait for interrupt, then read
    } cmd_t;

    localparam tof_bus_pkg::reg_addr_t DIST_BASE = 16'h0000;

    // First script table entry of each segment
    function automatic tof_bus_pkg::script_idx_t seg_first(input cmd_t cmd);
        case (cmd)
            SW_REBOOT1:    return 7'd0;
            SW_REBOOT2:    return 7'd15;
            SW_REBOOT3:    return 7'd17;
            RESET_MCU:     return 7'd47;
            START_RANGING: return 7'd63;
            default:       return 7'd0;
        endcase
    endfunction

endpackage

// File: hw/tof_script_rom.sv
`timescale 1ns/100ps
`include "tof_params.svh"

module tof_script_rom (
    input  tof_bus_pkg::script_idx_t   idx,
    output tof_bus_pkg::script_entry_t entry
);

    localparam int ENTRY_W = `TOF_ADDR_W + `TOF_DATA_W;
    localparam tof_bus_pkg::script_idx_t READ_IDX = 7'd4;  // 7FFF readback

    // {address, value}
    localparam logic [ENTRY_W-1:0] SCRIPT [`TOF_SCRIPT_LEN] = '{
        // Software reboot part 1
        24'h7FFF_00, 24'h0009_04, 24'h000F_40, 24'h000A_03, 24'h7FFF_00,
        24'h000C_01, 24'h0101_00, 24'h0102_00, 24'h010A_01, 24'h4002_01,
        24'h4002_00, 24'h010A_03, 24'h0103_01, 24'h000C_00, 24'h000F_43,
        // Part 2
        24'h000F_40, 24'h000A_01,
        // Part 3
        24'h7FFF_00, 24'h000E_01, 24'h7FFF_02,
        24'h0003_0D, 24'h7FFF_01, 24'h7FFF_00, 24'h000C_01, 24'h7FFF_00,
        24'h0101_00, 24'h0102_00, 24'h010A_01, 24'h4002_01, 24'h4002_00,
        24'h010A_03, 24'h0103_01, 24'h400F_00, 24'h021A_43, 24'h021A_03,
        24'h021A_01, 24'h021A_00, 24'h0219_00, 24'h021B_00, 24'h7FFF_00,
        24'h000C_00, 24'h7FFF_01, 24'h0020_07, 24'h0020_06, 24'h7FFF_09,
        24'h7FFF_0A, 24'h7FFF_0B,           // Bank writes, no command reaches them
        // MCU reset
        24'h7FFF_01, 24'h7FFF_02, 24'h0003_0D,
        24'h7FFF_01, 24'h7FFF_00, 24'h000C_01, 24'h7FFF_00, 24'h0114_00,
        24'h0115_00, 24'h0116_42, 24'h0117_00, 24'h000B_00, 24'h7FFF_00,
        24'h000C_00, 24'h000B_01, 24'h7FFF_02,
        // Start ranging
        24'h7FFF_00, 24'h0009_05, 24'h7FFF_02, 24'h2FFF_00, 24'h3000_03,
        24'h3001_00, 24'h3002_00
    };

    always_comb begin
        entry = '0;
        if (idx < `TOF_SCRIPT_LEN) begin
            entry.addr  = SCRIPT[idx][ENTRY_W-1:`TOF_DATA_W];
            entry.value = SCRIPT[idx][`TOF_DATA_W-1:0];
            entry.rd    = (idx == READ_IDX);
            // Segment ends
            entry.last  = idx inside {7'd14, 7'd16, 7'd44, 7'd62, 7'd69};
        end
    end

endmodule

// File: hw/tof_script_player.sv
`timescale 1ns/100ps

module tof_script_player (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       go,
    input  tof_bus_pkg::script_idx_t   first_idx,
    output tof_bus_pkg::script_idx_t   rom_idx,
    input  tof_bus_pkg::script_entry_t rom_entry,
    output logic                       bus_start,
    input  logic                       bus_ready,
    output tof_bus_pkg::reg_addr_t     reg_addr,
    output tof_bus_pkg::bus_byte_t     wr_data,
    output logic                       is_read,
    output logic                       done
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_LOAD,     // Fetch entry from table
        P_REQ,      // bus_start high
        P_REL       // Wait for bus_ready low
    } state_t;

    state_t                   state;
    tof_bus_pkg::script_idx_t idx;
    logic                     last_entry;

    assign rom_idx   = idx;
    assign bus_start = (state == P_REQ);

    ////////////////////////////////////////////////////////////
    // Entry sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= P_IDLE;
            idx        <= '0;
            last_entry <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (go) begin
                        idx   <= first_idx;
                        state <= P_LOAD;
                    end
                end
                P_LOAD: begin
                    last_entry <= rom_entry.last;
                    state      <= P_REQ;
                end
                P_REQ: begin
                    if (bus_ready)
                        state <= P_REL;
                end
                P_REL: begin
                    if (!bus_ready) begin
                        if (last_entry) begin
                            done  <= 1'b1;
                            state <= P_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= P_LOAD;
                        end
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Held through the whole transfer; read data is dropped
    always_ff @(posedge clk) begin
        if (state == P_LOAD) begin
            reg_addr <= rom_entry.addr;
            wr_data  <= rom_entry.value;
            is_read  <= rom_entry.rd;
        end
    end

endmodule

// File: hw/tof_frame_reader.sv
`timescale 1ns/100ps
`include "tof_params.svh"

module tof_frame_reader (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   go,
    output logic                   bus_start,
    input  logic                   bus_ready,
    output tof_bus_pkg::reg_addr_t reg_addr,
    input  tof_bus_pkg::bus_byte_t rd_data,
    output logic                   dist_valid,
    output tof_bus_pkg::distance_t dist_mm,
    output tof_bus_pkg::zone_t     zone_idx,
    output logic                   done
);

    localparam int CNT_W     = $clog2(`TOF_FRAME_BYTES);
    localparam int DIST_LAST = `TOF_DIST_FIRST + 2 * `TOF_ZONES - 1;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_REL
    } state_t;

    state_t                 state;
    logic [CNT_W-1:0]       byte_idx;
    logic [CNT_W-1:0]       dist_off;   // Byte offset into distance block
    logic                   in_dist;
    tof_bus_pkg::bus_byte_t hi_byte;

    assign bus_start = (state == F_REQ);
    assign reg_addr  = tof_cmd_pkg::DIST_BASE + tof_bus_pkg::reg_addr_t'(byte_idx);
    assign dist_off  = byte_idx - CNT_W'(`TOF_DIST_FIRST);
    assign in_dist   = (byte_idx >= CNT_W'(`TOF_DIST_FIRST)) &&
                       (byte_idx <= CNT_W'(DIST_LAST));

    ////////////////////////////////////////////////////////////
    // One single-byte read per frame byte
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= F_IDLE;
            byte_idx   <= '0;
            dist_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            dist_valid <= 1'b0;
            done       <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (go) begin
                        byte_idx <= '0;
                        state    <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (bus_ready) begin
                        dist_valid <= in_dist && dist_off[0];   // Low byte closes a zone
                        state      <= F_REL;
                    end
                end
                F_REL: begin
                    if (!bus_ready) begin
                        if (byte_idx == CNT_W'(`TOF_FRAME_BYTES - 1)) begin
                            done  <= 1'b1;
                            state <= F_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= F_REQ;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Big-endian pairs
    always_ff @(posedge clk) begin
        if (state == F_REQ && bus_ready && in_dist) begin
            if (dist_off[0]) begin
                dist_mm  <= {hi_byte, rd_data};
                zone_idx <= tof_bus_pkg::zone_t'(dist_off >> 1);
            end else begin
                hi_byte <= rd_data;
            end
        end
    end

endmodule

// File: hw/tof_sequencer.sv
`timescale 1ns/100ps

module tof_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_req,
    input  tof_cmd_pkg::cmd_t        cmd_code,
    output logic                     cmd_ack,
    input  logic                     tof_int,
    output logic                     play_go,
    output tof_bus_pkg::script_idx_t play_first,
    input  logic                     play_done,
    output logic                     read_go,
    input  logic                     read_done,
    input  logic                     play_start,
    input  logic                     read_start,
    input  tof_bus_pkg::reg_addr_t   play_addr,
    input  tof_bus_pkg::reg_addr_t   read_addr,
    input  tof_bus_pkg::bus_byte_t   play_data,
    input  logic                     play_is_read,
    output logic                     bus_start,
    output tof_bus_pkg::reg_addr_t   reg_addr,
    output tof_bus_pkg::bus_byte_t   wr_data,
    output logic                     is_read
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RUN_SCRIPT,
        S_WAIT_INT,
        S_READ_FRAME,
        S_ACK,
        S_RELEASE       // Hold ack until host drops req
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            cmd_ack <= 1'b0;
            play_go <= 1'b0;
            read_go <= 1'b0;
        end else begin
            play_go <= 1'b0;
            read_go <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_req) begin
                        case (cmd_code)
                            tof_cmd_pkg::SW_REBOOT1, tof_cmd_pkg::SW_REBOOT2,
                            tof_cmd_pkg::SW_REBOOT3, tof_cmd_pkg::RESET_MCU,
                            tof_cmd_pkg::START_RANGING: begin
                                play_go <= 1'b1;
                                state   <= S_RUN_SCRIPT;
                            end
                            tof_cmd_pkg::DOWNLOAD_DATA: begin
                                read_go <= 1'b1;
                                state   <= S_READ_FRAME;
                            end
                            tof_cmd_pkg::DATA_ACQUISITION: state <= S_WAIT_INT;
                            default: state <= S_ACK;    // Unsupported, ack only
                        endcase
                    end
                end
                S_RUN_SCRIPT: if (play_done) state <= S_ACK;
                S_WAIT_INT: begin
                    if (tof_int) begin
                        read_go <= 1'b1;
                        state   <= S_READ_FRAME;
                    end
                end
                S_READ_FRAME: if (read_done) state <= S_ACK;
                S_ACK: begin
                    cmd_ack <= 1'b1;
                    state   <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE)
            play_first <= tof_cmd_pkg::seg_first(cmd_code);
    end

    // Bus goes to whichever engine is running
    always_comb begin
        bus_start = 1'b0;
        reg_addr  = '0;
        wr_data   = '0;
        is_read   = 1'b0;
        if (state == S_RUN_SCRIPT) begin
            bus_start = play_start;
            reg_addr  = play_addr;
            wr_data   = play_data;
            is_read   = play_is_read;
        end else if (state == S_READ_FRAME) begin
            bus_start = read_start;
            reg_addr  = read_addr;
            is_read   = 1'b1;
        end
    end

endmodule

// File: hw/tof_ctrl_top.sv
`timescale 1ns/100ps

module tof_ctrl_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_req,
    input  tof_cmd_pkg::cmd_t      cmd_code,
    output logic                   cmd_ack,
    input  logic                   tof_int,
    output logic                   bus_start,
    input  logic                   bus_ready,
    output tof_bus_pkg::reg_addr_t reg_addr,
    output tof_bus_pkg::bus_byte_t wr_data,
    output logic                   is_read,
    input  tof_bus_pkg::bus_byte_t rd_data,
    output logic                   dist_valid,
    output tof_bus_pkg::distance_t dist_mm,
    output tof_bus_pkg::zone_t     zone_idx
);

    logic                       play_go, play_done, play_start, play_is_read;
    logic                       read_go, read_done, read_start;
    tof_bus_pkg::script_idx_t   play_first, rom_idx;
    tof_bus_pkg::script_entry_t rom_entry;
    tof_bus_pkg::reg_addr_t     play_addr, read_addr;
    tof_bus_pkg::bus_byte_t     play_data;

    tof_sequencer u_seq (
        .clk, .reset, .cmd_req, .cmd_code, .cmd_ack, .tof_int,
        .play_go, .play_first, .play_done, .read_go, .read_done,
        .play_start, .read_start, .play_addr, .read_addr,
        .play_data, .play_is_read,
        .bus_start, .reg_addr, .wr_data, .is_read
    );

    tof_script_player u_player (
        .clk, .reset, .go(play_go), .first_idx(play_first),
        .rom_idx, .rom_entry, .bus_start(play_start), .bus_ready,
        .reg_addr(play_addr), .wr_data(play_data), .is_read(play_is_read),
        .done(play_done)
    );

    tof_script_rom u_rom (.idx(rom_idx), .entry(rom_entry));

    tof_frame_reader u_reader (
        .clk, .reset, .go(read_go), .bus_start(read_start), .bus_ready,
        .reg_addr(read_addr), .rd_data, .dist_valid, .dist_mm, .zone_idx,
        .done(read_done)
    );

endmodule

// File: dv/tof_ctrl_chk.sv
`timescale 1ns/100ps

module tof_ctrl_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   cmd_req,
    input logic                   cmd_ack,
    input logic                   bus_start,
    input logic                   bus_ready,
    input tof_bus_pkg::reg_addr_t reg_addr,
    input tof_bus_pkg::bus_byte_t wr_data,
    input logic                   is_read
);

    int assert_fails = 0;

    // Request and its fields hold until the master answers
    bus_hold: assert property (@(posedge clk) disable iff (reset)
        bus_start && !bus_ready |=> bus_start && $stable(reg_addr) &&
                                    $stable(wr_data) && $stable(is_read))
    else begin
        $error("bus_start dropped or bus fields changed before bus_ready");
        assert_fails++;
    end

    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ack) |-> cmd_req)
    else begin
        $error("cmd_ack rose without cmd_req");
        assert_fails++;
    end

    // Host may raise the next req as soon as ack is low
    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(cmd_ack) |-> $past(!cmd_req))
    else begin
        $error("cmd_ack fell before cmd_req was released");
        assert_fails++;
    end

endmodule

bind tof_ctrl_top tof_ctrl_chk u_chk (.*);

// File: dv/tof_ctrl_tb.sv
`timescale 1ns/100ps
`include "tof_params.svh"

module tof_ctrl_tb;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_CYCLES = 20000;  // Two frames of 180 x ~9 cycles plus scripts, with margin

    logic                   clk = 1'b0;
    logic                   reset, cmd_req, cmd_ack, tof_int;
    tof_cmd_pkg::cmd_t      cmd_code;
    logic                   bus_start, bus_ready, is_read, dist_valid;
    tof_bus_pkg::reg_addr_t reg_addr;
    tof_bus_pkg::bus_byte_t wr_data, rd_data;
    tof_bus_pkg::distance_t dist_mm;
    tof_bus_pkg::zone_t     zone_idx;

    tof_bus_pkg::reg_addr_t txn_addr[$];
    tof_bus_pkg::bus_byte_t txn_data[$];
    logic                   txn_rd[$];
    tof_bus_pkg::distance_t dist_log[$];
    tof_bus_pkg::zone_t     zone_log[$];
    int unsigned            resp_delay;
    int                     cycle_count = 0;
    int                     err_count = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;

    tof_ctrl_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic tof_bus_pkg::bus_byte_t resp_byte(input tof_bus_pkg::reg_addr_t addr);
        return addr[7:0] ^ 8'h5A;
    endfunction

    ////////////////////////////////////////////////////////////
    // I2C responder, distance monitor, timeout
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h9bf8_1be0));
        forever begin
            step();
            if (!reset && bus_start && !bus_ready) begin
                resp_delay = $urandom_range(3, 0);
                repeat (resp_delay) step();
                txn_addr.push_back(reg_addr);
                txn_data.push_back(wr_data);
                txn_rd.push_back(is_read);
                rd_data   = resp_byte(reg_addr);
                bus_ready = 1'b1;
                do step(); while (bus_start);
                bus_ready = 1'b0;
            end
        end
    end

    always begin
        step();
        if (dist_valid) begin
            dist_log.push_back(dist_mm);
            zone_log.push_back(zone_idx);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic start_cmd(input tof_cmd_pkg::cmd_t code);
        txn_addr.delete();
        txn_data.delete();
        txn_rd.delete();
        dist_log.delete();
        zone_log.delete();
        cmd_code = code;
        cmd_req  = 1'b1;
    endtask

    // Ack must hold while the host is slow to release
    task automatic finish_cmd();
        while (!cmd_ack) step();
        repeat (2) begin
            step();
            if (!cmd_ack) flag_error("cmd_ack dropped while cmd_req still high");
        end
        cmd_req = 1'b0;
        while (cmd_ack) step();
    endtask

    task automatic check_writes(input tof_bus_pkg::reg_addr_t ea[$],
                                input tof_bus_pkg::bus_byte_t ed[$]);
        if (txn_addr.size() != ea.size())
            flag_error($sformatf("%0d transactions, expected %0d", txn_addr.size(), ea.size()));
        else
            for (int i = 0; i < ea.size(); i++)
                if (txn_rd[i] || txn_addr[i] !== ea[i] || txn_data[i] !== ed[i])
                    flag_error($sformatf("txn %0d got rd=%b %h <- %h, expected write %h <- %h",
                                         i, txn_rd[i], txn_addr[i], txn_data[i], ea[i], ed[i]));
    endtask

    task automatic check_frame();
        tof_bus_pkg::distance_t exp_mm;
        if (txn_addr.size() != `TOF_FRAME_BYTES)
            flag_error($sformatf("%0d frame reads, expected %0d",
                                 txn_addr.size(), `TOF_FRAME_BYTES));
        for (int i = 0; i < txn_addr.size(); i++)
            if (!txn_rd[i] || txn_addr[i] !== 16'(i))
                flag_error($sformatf("frame txn %0d got rd=%b addr %h", i, txn_rd[i], txn_addr[i]));
        if (dist_log.size() != `TOF_ZONES)
            flag_error($sformatf("%0d distance pulses, expected %0d",
                                 dist_log.size(), `TOF_ZONES));
        for (int z = 0; z < dist_log.size(); z++) begin
            exp_mm = {resp_byte(16'(`TOF_DIST_FIRST + 2 * z)),
                      resp_byte(16'(`TOF_DIST_FIRST + 2 * z + 1))};
            if (dist_log[z] !== exp_mm || zone_log[z] !== 6'(z))
                flag_error($sformatf("pulse %0d got zone %0d = %h, expected zone %0d = %h",
                                     z, zone_log[z], dist_log[z], z, exp_mm));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        int errs;
        errs = err_count;
        repeat (10) begin
            step();
            if (cmd_ack || bus_start || dist_valid)
                flag_error("output active after reset with no command");
        end
        end_test("reset_idle", errs);
    endtask

    task automatic test_script(input string name, input tof_cmd_pkg::cmd_t code);
        int errs;
        errs = err_count;
        start_cmd(code);
        finish_cmd();
        if (code == tof_cmd_pkg::SW_REBOOT2)
            check_writes('{16'h000F, 16'h000A}, '{8'h40, 8'h01});
        else if (code == tof_cmd_pkg::START_RANGING)
            check_writes('{16'h7FFF, 16'h0009, 16'h7FFF, 16'h2FFF, 16'h3000, 16'h3001, 16'h3002},
                         '{8'h00, 8'h05, 8'h02, 8'h00, 8'h03, 8'h00, 8'h00});
        else begin
            if (txn_addr.size() != 15)
                flag_error($sformatf("%0d transactions, expected 15", txn_addr.size()));
            for (int i = 0; i < txn_addr.size(); i++)
                if (txn_rd[i] != (i == 4) || (i == 4 && txn_addr[i] !== 16'h7FFF))
                    flag_error($sformatf("txn %0d got rd=%b addr %h", i, txn_rd[i], txn_addr[i]));
        end
        end_test(name, errs);
    endtask

    task automatic test_download();
        int errs;
        errs = err_count;
        start_cmd(tof_cmd_pkg::DOWNLOAD_DATA);
        finish_cmd();
        check_frame();
        end_test("download_data", errs);
    endtask

    task automatic test_acquisition();
        int errs;
        errs = err_count;
        start_cmd(tof_cmd_pkg::DATA_ACQUISITION);
        repeat (20) begin
            step();
            if (bus_start || txn_addr.size() != 0 || cmd_ack)
                flag_error("bus activity or ack before tof_int");
        end
        tof_int = 1'b1;
        step();
        tof_int = 1'b0;
        finish_cmd();
        check_frame();
        end_test("data_acquisition", errs);
    endtask

    task automatic test_unsupported();
        int errs;
        int wait_cycles;
        errs = err_count;
        wait_cycles = 0;
        start_cmd(tof_cmd_pkg::cmd_t'(4'd5));
        while (!cmd_ack) begin
            step();
            wait_cycles++;
        end
        if (wait_cycles != 2)
            flag_error($sformatf("ack after %0d cycles, expected 2", wait_cycles));
        finish_cmd();
        if (txn_addr.size() != 0 || dist_log.size() != 0)
            flag_error("unsupported code caused bus or distance activity");
        end_test("unsupported_code", errs);
    endtask

    initial begin
        reset     = 1'b1;
        cmd_req   = 1'b0;
        cmd_code  = tof_cmd_pkg::SW_REBOOT1;
        tof_int   = 1'b0;
        bus_ready = 1'b0;
        rd_data   = '0;
        repeat (3) step();
        reset = 1'b0;

        test_reset_idle();
        test_script("sw_reboot2", tof_cmd_pkg::SW_REBOOT2);
        test_script("sw_reboot1", tof_cmd_pkg::SW_REBOOT1);
        test_script("start_ranging", tof_cmd_pkg::START_RANGING);
        test_download();
        test_acquisition();
        test_unsupported();

        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, uut.u_chk.assert_fails);
        if (tests_failed == 0 && uut.u_chk.assert_fails == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/tof_bus_pkg.sv
hw/tof_cmd_pkg.sv
hw/tof_script_rom.sv
hw/tof_script_player.sv
hw/tof_frame_reader.sv
hw/tof_sequencer.sv
hw/tof_ctrl_top.sv
dv/tof_ctrl_chk.sv
dv/tof_ctrl_tb.sv
